// ==== hdl/alu_add8.sv ====
`timescale 1ns/1ps

module alu_add8 (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       en,
   input  logic [alu_pkg::fn_w-1:0]   func,
   input  logic [alu_pkg::data_w-1:0] data_in1,
   input  logic [alu_pkg::data_w-1:0] data_in2,
   output logic [alu_pkg::data_w-1:0] add_res,
   output logic                       carry
);

   import alu_pkg::*;

   // high for subtract and subtract with borrow
   logic              sub;
   // second operand after the optional inversion
   logic [data_w-1:0] b_op;
   // carry into the low bit
   logic              cin;
   // one bit wider than the data to catch the carry out
   logic [data_w:0]   sum;
   // flag value that the next enabled edge stores
   logic              carry_nxt;

   assign sub  = (func == fn_sub) || (func == fn_sbb);
   assign b_op = sub ? ~data_in2 : data_in2;

   // subtraction is a + ~b + 1, so a stored borrow removes that extra one
   always_comb begin
      unique case (func)
         fn_add:  cin = 1'b0;
         fn_adc:  cin = carry;
         fn_sub:  cin = 1'b1;
         fn_sbb:  cin = ~carry;
         default: cin = 1'b0;
      endcase
   end

   // a single adder covers all four functions
   assign sum     = {1'b0, data_in1} + {1'b0, b_op} + {{data_w{1'b0}}, cin};
   assign add_res = sum[data_w-1:0];

   // after a subtraction a missing carry out means a borrow took place
   assign carry_nxt = sub ? ~sum[data_w] : sum[data_w];

   // the flag only moves when the adder group is active
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         carry <= 1'b0;
      end else if (en) begin
         carry <= carry_nxt;
      end
   end

endmodule

// ==== hdl/alu_cmp8.sv ====
`timescale 1ns/1ps

module alu_cmp8 (
   input  logic [alu_pkg::data_w-1:0] data_in1,
   input  logic [alu_pkg::data_w-1:0] data_in2,
   input  logic [alu_pkg::fn_w-1:0]   func,
   output logic [alu_pkg::data_w-1:0] cmp_res
);

   import alu_pkg::*;

   // unsigned magnitude relations, each computed a single time
   logic gt;
   logic eq;
   logic lt;

   assign gt = (data_in1 > data_in2);
   assign eq = (data_in1 == data_in2);
   assign lt = (data_in1 < data_in2);

   ////////////////////////////////////////////////////////////////////////////
   // result forming
   ////////////////////////////////////////////////////////////////////////////

   // the flag word puts greater on bit 2, equal on bit 1 and less on bit 0
   // the upper bits of the flag word stay at zero
   // minimum and maximum reuse the same relations instead of new comparators
   always_comb begin
      cmp_res = '0;
      unique case (func)
         fn_flags: begin
            cmp_res[2:0] = {gt, eq, lt};
         end
         fn_min: begin
            cmp_res = lt ? data_in1 : data_in2;
         end
         fn_max: begin
            cmp_res = gt ? data_in1 : data_in2;
         end
         default: begin
            // the reserved code keeps the zero set above
            cmp_res = '0;
         end
      endcase
   end

   // when the operands are equal both choices give the same byte
   // so min and max need no tie rule

endmodule

// ==== hdl/alu_ctrl.sv ====
`timescale 1ns/1ps

module alu_ctrl (
   input  logic                       clk,
   input  logic                       arst_n,
   input  alu_pkg::op_u               op,
   input  logic [alu_pkg::data_w-1:0] add_res,
   input  logic [alu_pkg::data_w-1:0] cmp_res,
   input  logic [alu_pkg::data_w-1:0] logic_res,
   input  logic [alu_pkg::data_w-1:0] shift_res,
   output logic [alu_pkg::fn_w-1:0]   func,
   output logic                       add_en,
   output logic                       shift_en,
   output logic [alu_pkg::data_w-1:0] data_out
);

   import alu_pkg::*;

   // group field of the current opcode
   logic [fn_w-1:0]   grp;

   // result of the unit that the group selects, before the output register
   logic [data_w-1:0] res_sel;

   ////////////////////////////////////////////////////////////////////////////
   // opcode decode
   ////////////////////////////////////////////////////////////////////////////

   // the upper field names the unit and the lower field goes to every unit as is
   assign grp  = op.fields[grp_idx];
   assign func = op.fields[fn_idx];

   // only the adder and the shift register hold state
   // so only those two need an enable to keep their state quiet
   // when another group is running
   assign add_en   = (grp == grp_add);
   assign shift_en = (grp == grp_shift);

   ////////////////////////////////////////////////////////////////////////////
   // result selection
   ////////////////////////////////////////////////////////////////////////////

   // all four units compute every cycle and the group picks one answer
   // this takes the place of the demux/mux pair around the units
   always_comb begin
      unique case (grp)
         grp_add: begin
            res_sel = add_res;
         end
         grp_cmp: begin
            res_sel = cmp_res;
         end
         grp_logic: begin
            res_sel = logic_res;
         end
         grp_shift: begin
            res_sel = shift_res;
         end
         default: begin
            res_sel = '0;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // output register
   ////////////////////////////////////////////////////////////////////////////

   // the answer appears on data_out right after the edge that sampled op
   // which gives the one cycle latency of the whole block
   // the carry flag and the shift register move on the same edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_out <= '0;
      end else begin
         data_out <= res_sel;
      end
   end

endmodule

// ==== hdl/alu_logic8.sv ====
`timescale 1ns/1ps

module alu_logic8 (
   input  logic [alu_pkg::data_w-1:0] data_in1,
   input  logic [alu_pkg::data_w-1:0] data_in2,
   input  logic [alu_pkg::fn_w-1:0]   func,
   output logic [alu_pkg::data_w-1:0] logic_res
);

   import alu_pkg::*;

   // bitwise operations with no state and no carry
   // not takes only the first operand and ignores the second
   always_comb begin
      unique case (func)
         fn_and: begin
            logic_res = data_in1 & data_in2;
         end
         fn_or: begin
            logic_res = data_in1 | data_in2;
         end
         fn_xor: begin
            logic_res = data_in1 ^ data_in2;
         end
         fn_not: begin
            logic_res = ~data_in1;
         end
         default: begin
            logic_res = '0;
         end
      endcase
   end

endmodule

// ==== hdl/alu_pkg.sv ====
package alu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////////////////////

   // every datapath unit works on bytes of this width
   localparam int data_w = 8;

   // the opcode is four bits wide and splits into two fields of two bits
   localparam int op_w = 4;
   localparam int fn_w = 2;

   // position of each field inside the split view of the opcode
   localparam int grp_idx = 1;
   localparam int fn_idx  = 0;

   ////////////////////////////////////////////////////////////////////////////
   // opcode
   ////////////////////////////////////////////////////////////////////////////

   // the same four bits are seen either as one raw code or as a group/function pair
   // the group lives in the upper field and the function in the lower one
   typedef union packed {
      logic [op_w-1:0]      code;
      logic [1:0][fn_w-1:0] fields;
   } op_u;

   // group codes pick which unit answers the operation
   localparam logic [fn_w-1:0] grp_add   = 2'd0;
   localparam logic [fn_w-1:0] grp_cmp   = 2'd1;
   localparam logic [fn_w-1:0] grp_logic = 2'd2;
   localparam logic [fn_w-1:0] grp_shift = 2'd3;

   // adder functions, the upper bit marks a subtraction
   localparam logic [fn_w-1:0] fn_add = 2'd0;
   localparam logic [fn_w-1:0] fn_adc = 2'd1;
   localparam logic [fn_w-1:0] fn_sub = 2'd2;
   localparam logic [fn_w-1:0] fn_sbb = 2'd3;

   // comparator functions, code 3 is reserved and returns zero
   localparam logic [fn_w-1:0] fn_flags = 2'd0;
   localparam logic [fn_w-1:0] fn_min   = 2'd1;
   localparam logic [fn_w-1:0] fn_max   = 2'd2;

   // logic functions
   localparam logic [fn_w-1:0] fn_and = 2'd0;
   localparam logic [fn_w-1:0] fn_or  = 2'd1;
   localparam logic [fn_w-1:0] fn_xor = 2'd2;
   localparam logic [fn_w-1:0] fn_not = 2'd3;

   // shift register functions
   localparam logic [fn_w-1:0] fn_load = 2'd0;
   localparam logic [fn_w-1:0] fn_shr  = 2'd1;
   localparam logic [fn_w-1:0] fn_shl  = 2'd2;
   localparam logic [fn_w-1:0] fn_read = 2'd3;

endpackage

// ==== hdl/alu_regdec.sv ====
`timescale 1ns/1ps

module alu_regdec (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       en,
   input  logic [alu_pkg::fn_w-1:0]   func,
   input  logic [alu_pkg::data_w-1:0] data_in1,
   input  logic                       ser_in,
   output logic [alu_pkg::data_w-1:0] shift_res
);

   import alu_pkg::*;

   // stored shift register contents
   logic [data_w-1:0] sreg;
   // value the register takes at the next enabled edge
   logic [data_w-1:0] sreg_nxt;

   ////////////////////////////////////////////////////////////////////////////
   // next value
   ////////////////////////////////////////////////////////////////////////////

   // a right shift feeds the serial bit into the top
   // a left shift feeds it into the bottom
   // read simply holds the current value
   always_comb begin
      unique case (func)
         fn_load: begin
            sreg_nxt = data_in1;
         end
         fn_shr: begin
            sreg_nxt = {ser_in, sreg[data_w-1:1]};
         end
         fn_shl: begin
            sreg_nxt = {sreg[data_w-2:0], ser_in};
         end
         fn_read: begin
            sreg_nxt = sreg;
         end
         default: begin
            sreg_nxt = sreg;
         end
      endcase
   end

   // the result is the value after the operation
   // so the output register and sreg take the same byte on the same edge
   assign shift_res = sreg_nxt;

   ////////////////////////////////////////////////////////////////////////////
   // storage
   ////////////////////////////////////////////////////////////////////////////

   // the register only moves when the shift group is active
   // so other groups never disturb its contents
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sreg <= '0;
      end else if (en) begin
         sreg <= sreg_nxt;
      end
   end

endmodule

// ==== hdl/alu_top.sv ====
`timescale 1ns/1ps

module alu_top (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic [alu_pkg::op_w-1:0]   op,
   input  logic [alu_pkg::data_w-1:0] data_in1,
   input  logic [alu_pkg::data_w-1:0] data_in2,
   output logic [alu_pkg::data_w-1:0] data_out,
   output logic                       carry
);

   import alu_pkg::*;

   // function field shared by all units
   logic [fn_w-1:0]   func;

   // enables for the two units that keep state
   logic              add_en;
   logic              shift_en;

   // unit results going back to the control module
   logic [data_w-1:0] add_res;
   logic [data_w-1:0] cmp_res;
   logic [data_w-1:0] logic_res;
   logic [data_w-1:0] shift_res;

   ////////////////////////////////////////////////////////////////////////////
   // control
   ////////////////////////////////////////////////////////////////////////////

   // the raw opcode enters here and is split into its two fields
   alu_ctrl u_ctrl (
      .clk       (clk),
      .arst_n    (arst_n),
      .op        (op),
      .add_res   (add_res),
      .cmp_res   (cmp_res),
      .logic_res (logic_res),
      .shift_res (shift_res),
      .func      (func),
      .add_en    (add_en),
      .shift_en  (shift_en),
      .data_out  (data_out)
   );

   ////////////////////////////////////////////////////////////////////////////
   // datapath units
   ////////////////////////////////////////////////////////////////////////////

   // adder and subtractor, also the owner of the carry flag
   alu_add8 u_add8 (
      .clk      (clk),
      .arst_n   (arst_n),
      .en       (add_en),
      .func     (func),
      .data_in1 (data_in1),
      .data_in2 (data_in2),
      .add_res  (add_res),
      .carry    (carry)
   );

   alu_cmp8 u_cmp8 (
      .data_in1 (data_in1),
      .data_in2 (data_in2),
      .func     (func),
      .cmp_res  (cmp_res)
   );

   alu_logic8 u_logic8 (
      .data_in1  (data_in1),
      .data_in2  (data_in2),
      .func      (func),
      .logic_res (logic_res)
   );

   // bit 0 of the second operand is the serial input for both shift directions
   alu_regdec u_regdec (
      .clk       (clk),
      .arst_n    (arst_n),
      .en        (shift_en),
      .func      (func),
      .data_in1  (data_in1),
      .ser_in    (data_in2[0]),
      .shift_res (shift_res)
   );

endmodule

// ==== tb.f ====
hdl/alu_pkg.sv
hdl/alu_ctrl.sv
hdl/alu_add8.sv
hdl/alu_cmp8.sv
hdl/alu_logic8.sv
hdl/alu_regdec.sv
hdl/alu_top.sv
verif/alu_tb.sv

// ==== verif/alu_tb.sv ====
`timescale 1ns/1ps

module alu_tb;

   import alu_pkg::*;

   // random operations applied after the directed table
   localparam int n_rand = 200;
   // cycles that reset is held low
   localparam int rst_cycles = 4;

   logic             clk;
   logic             arst_n;
   logic [op_w-1:0]  op;
   logic [data_w-1:0] data_in1;
   logic [data_w-1:0] data_in2;
   logic [data_w-1:0] data_out;
   logic             carry;

   // directed table, one entry per cycle
   string             t_name[$];
   logic [op_w-1:0]   t_op[$];
   logic [data_w-1:0] t_a[$];
   logic [data_w-1:0] t_b[$];
   logic [data_w-1:0] t_d[$];
   logic              t_c[$];

   int check_cnt;
   int err_cnt;
   int test_cnt;

   // the reference model keeps its own copy of the carry flag and the shift register
   logic              mdl_carry;
   logic [data_w-1:0] mdl_sreg;

   alu_top DUT (
      .clk      (clk),
      .arst_n   (arst_n),
      .op       (op),
      .data_in1 (data_in1),
      .data_in2 (data_in2),
      .data_out (data_out),
      .carry    (carry)
   );

   always #4 clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic add_vec(input string name, input logic [op_w-1:0] o,
                          input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                          input logic [data_w-1:0] d, input logic c);
      t_name.push_back(name);
      t_op.push_back(o);
      t_a.push_back(a);
      t_b.push_back(b);
      t_d.push_back(d);
      t_c.push_back(c);
   endtask

   task automatic check_byte(input string sig, input logic [data_w-1:0] exp_v,
                             input logic [data_w-1:0] act_v);
      check_cnt++;
      if (act_v !== exp_v) begin
         err_cnt++;
         $display("CHECK FAILED time %0t: %s expected 0x%02h got 0x%02h",
                  $time, sig, exp_v, act_v);
      end
   endtask

   task automatic check_bit(input string sig, input logic exp_v, input logic act_v);
      check_cnt++;
      if (act_v !== exp_v) begin
         err_cnt++;
         $display("CHECK FAILED time %0t: %s expected %b got %b", $time, sig, exp_v, act_v);
      end
   endtask

   // called on a falling edge, drives one operation and checks it at the next falling edge
   // the next call drives right away, so operations go out back to back
   task automatic run_vec(input logic [op_w-1:0] o, input logic [data_w-1:0] a,
                          input logic [data_w-1:0] b, input logic [data_w-1:0] exp_d,
                          input logic exp_c);
      op       = o;
      data_in1 = a;
      data_in2 = b;
      @(negedge clk);
      check_byte("data_out", exp_d, data_out);
      check_bit("carry", exp_c, carry);
   endtask

   // model of the operation rules, written with plain integer arithmetic
   task automatic predict_result(input logic [op_w-1:0] o, input logic [data_w-1:0] a,
                                 input logic [data_w-1:0] b, output logic [data_w-1:0] d);
      int s;
      logic [1:0] g;
      logic [1:0] f;
      g = o[3:2];
      f = o[1:0];
      d = '0;
      if (g == grp_add) begin
         if (f == fn_add || f == fn_adc) begin
            s = int'(a) + int'(b) + ((f == fn_adc) ? int'(mdl_carry) : 0);
            d = s[7:0];
            mdl_carry = (s > 255);
         end else begin
            s = int'(a) - int'(b) - ((f == fn_sbb) ? int'(mdl_carry) : 0);
            d = s[7:0];
            mdl_carry = (s < 0);
         end
      end else if (g == grp_cmp) begin
         if (f == fn_flags)
            d = (a > b) ? 8'h04 : ((a == b) ? 8'h02 : 8'h01);
         else if (f == fn_min)
            d = (a < b) ? a : b;
         else if (f == fn_max)
            d = (a > b) ? a : b;
      end else if (g == grp_logic) begin
         if (f == fn_and) d = a & b;
         else if (f == fn_or) d = a | b;
         else if (f == fn_xor) d = a ^ b;
         else d = ~a;
      end else begin
         if (f == fn_load) mdl_sreg = a;
         else if (f == fn_shr) mdl_sreg = {b[0], mdl_sreg[7:1]};
         else if (f == fn_shl) mdl_sreg = {mdl_sreg[6:0], b[0]};
         d = mdl_sreg;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed table
   ////////////////////////////////////////////////////////////////////////////

   // expected values worked out by hand, carry column is the flag after the entry
   task automatic build_table();
      add_vec("read after reset", {grp_shift, fn_read}, 8'h55, 8'h00, 8'h00, 1'b0);
      add_vec("add plain", {grp_add, fn_add}, 8'h12, 8'h34, 8'h46, 1'b0);
      add_vec("add overflow", {grp_add, fn_add}, 8'hf0, 8'h20, 8'h10, 1'b1);
      add_vec("adc uses carry", {grp_add, fn_adc}, 8'h01, 8'h01, 8'h03, 1'b0);
      add_vec("add wrap to zero", {grp_add, fn_add}, 8'hff, 8'h01, 8'h00, 1'b1);
      add_vec("adc chain carry", {grp_add, fn_adc}, 8'hff, 8'h00, 8'h00, 1'b1);
      add_vec("adc chain end", {grp_add, fn_adc}, 8'h10, 8'h20, 8'h31, 1'b0);
      add_vec("sub plain", {grp_add, fn_sub}, 8'h50, 8'h20, 8'h30, 1'b0);
      add_vec("sub borrow", {grp_add, fn_sub}, 8'h20, 8'h50, 8'hd0, 1'b1);
      add_vec("sbb uses borrow", {grp_add, fn_sbb}, 8'h10, 8'h05, 8'h0a, 1'b0);
      add_vec("sub under zero", {grp_add, fn_sub}, 8'h00, 8'h01, 8'hff, 1'b1);
      add_vec("sbb chain borrow", {grp_add, fn_sbb}, 8'h00, 8'h00, 8'hff, 1'b1);
      add_vec("sbb chain end", {grp_add, fn_sbb}, 8'h05, 8'h03, 8'h01, 1'b0);
      add_vec("sub equal", {grp_add, fn_sub}, 8'h7f, 8'h7f, 8'h00, 1'b0);
      add_vec("add sets carry", {grp_add, fn_add}, 8'h80, 8'h80, 8'h00, 1'b1);
      // from here the carry stays at one through the comparator and logic groups
      add_vec("flags greater", {grp_cmp, fn_flags}, 8'h40, 8'h20, 8'h04, 1'b1);
      add_vec("flags equal", {grp_cmp, fn_flags}, 8'h33, 8'h33, 8'h02, 1'b1);
      add_vec("flags less", {grp_cmp, fn_flags}, 8'h01, 8'hfe, 8'h01, 1'b1);
      add_vec("min greater", {grp_cmp, fn_min}, 8'h40, 8'h20, 8'h20, 1'b1);
      add_vec("min less", {grp_cmp, fn_min}, 8'h10, 8'h90, 8'h10, 1'b1);
      add_vec("max greater", {grp_cmp, fn_max}, 8'h40, 8'h20, 8'h40, 1'b1);
      add_vec("max less", {grp_cmp, fn_max}, 8'h10, 8'h90, 8'h90, 1'b1);
      add_vec("min equal", {grp_cmp, fn_min}, 8'h77, 8'h77, 8'h77, 1'b1);
      add_vec("cmp reserved", {grp_cmp, 2'd3}, 8'haa, 8'h55, 8'h00, 1'b1);
      add_vec("and", {grp_logic, fn_and}, 8'hf0, 8'h3c, 8'h30, 1'b1);
      add_vec("or nibbles", {grp_logic, fn_or}, 8'hf0, 8'h0f, 8'hff, 1'b1);
      add_vec("or sparse", {grp_logic, fn_or}, 8'ha0, 8'h05, 8'ha5, 1'b1);
      add_vec("xor", {grp_logic, fn_xor}, 8'hff, 8'h5a, 8'ha5, 1'b1);
      add_vec("xor self", {grp_logic, fn_xor}, 8'h3c, 8'h3c, 8'h00, 1'b1);
      add_vec("not", {grp_logic, fn_not}, 8'h0f, 8'hff, 8'hf0, 1'b1);
      add_vec("not zero", {grp_logic, fn_not}, 8'h00, 8'h12, 8'hff, 1'b1);
      add_vec("sub clears carry", {grp_add, fn_sub}, 8'h09, 8'h04, 8'h05, 1'b0);
      // these operands would give a carry out if the adder took them
      add_vec("and keeps carry", {grp_logic, fn_and}, 8'hff, 8'hf0, 8'hf0, 1'b0);
      // shift register walk, serial bit is bit 0 of the second operand
      add_vec("load", {grp_shift, fn_load}, 8'h96, 8'h00, 8'h96, 1'b0);
      add_vec("shr ser 0", {grp_shift, fn_shr}, 8'h00, 8'h00, 8'h4b, 1'b0);
      add_vec("shr ser 1", {grp_shift, fn_shr}, 8'h00, 8'h01, 8'ha5, 1'b0);
      add_vec("shl ser 0", {grp_shift, fn_shl}, 8'hff, 8'h00, 8'h4a, 1'b0);
      add_vec("shl ser 1", {grp_shift, fn_shl}, 8'h00, 8'hff, 8'h95, 1'b0);
      add_vec("read", {grp_shift, fn_read}, 8'h00, 8'h00, 8'h95, 1'b0);
      add_vec("add between", {grp_add, fn_add}, 8'h01, 8'h02, 8'h03, 1'b0);
      add_vec("xor between", {grp_logic, fn_xor}, 8'h11, 8'h22, 8'h33, 1'b0);
      add_vec("flags between", {grp_cmp, fn_flags}, 8'h05, 8'h06, 8'h01, 1'b0);
      add_vec("read survives", {grp_shift, fn_read}, 8'hee, 8'h01, 8'h95, 1'b0);
      add_vec("shr odd operand", {grp_shift, fn_shr}, 8'h00, 8'hfe, 8'h4a, 1'b0);
      add_vec("load zero", {grp_shift, fn_load}, 8'h00, 8'h00, 8'h00, 1'b0);
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      int seed;
      int err_before;
      logic [op_w-1:0]   r_op;
      logic [data_w-1:0] r_a;
      logic [data_w-1:0] r_b;
      logic [data_w-1:0] r_d;
      seed = 32'hc130ca65;
      void'($urandom(seed));
      clk       = 1'b0;
      arst_n    = 1'b0;
      op        = '0;
      data_in1  = '0;
      data_in2  = '0;
      check_cnt = 0;
      err_cnt   = 0;
      test_cnt  = 0;
      build_table();

      repeat (rst_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;

      // reset values before any operation
      err_before = err_cnt;
      check_byte("data_out", 8'h00, data_out);
      check_bit("carry", 1'b0, carry);
      test_cnt++;
      $display("test reset values: %s", (err_cnt == err_before) ? "ok" : "FAILED");

      for (int i = 0; i < t_op.size(); i++) begin
         err_before = err_cnt;
         run_vec(t_op[i], t_a[i], t_b[i], t_d[i], t_c[i]);
         test_cnt++;
         $display("test %0d %s: %s", i, t_name[i], (err_cnt == err_before) ? "ok" : "FAILED");
      end

      // the table ends with a cleared carry and an empty shift register
      mdl_carry  = 1'b0;
      mdl_sreg   = 8'h00;
      err_before = err_cnt;
      for (int i = 0; i < n_rand; i++) begin
         r_op = $urandom;
         r_a  = $urandom;
         r_b  = $urandom;
         predict_result(r_op, r_a, r_b, r_d);
         run_vec(r_op, r_a, r_b, r_d, mdl_carry);
      end
      test_cnt++;
      $display("test random %0d operations: %s", n_rand,
               (err_cnt == err_before) ? "ok" : "FAILED");

      $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   // limit is twice the cycles the whole run needs
   initial begin
      #1;
      #((t_op.size() + n_rand + rst_cycles) * 8 * 2);
      $display("watchdog timeout, the run did not finish in the expected time");
      $display("Regression failed");
      $finish;
   end

endmodule
